//--- design/fibCalc_defines.svh
`ifndef FIBCALC_DEFINES_SVH
`define FIBCALC_DEFINES_SVH

////////////////////////////////////////////////////////////////////////
// datapath sizing
////////////////////////////////////////////////////////////////////////

// width of every term and every register
`define FIB_DATA_W 16

// register file depth, terms rotate through all of them
`define FIB_NUM_REGS 16

// index into the register file, log2 of FIB_NUM_REGS
`define FIB_REG_IDX_W 4

// term numbers run 0..31
`define FIB_COUNT_W 5

`endif

//--- design/fibCalcPkg.sv
package fibCalcPkg;

    ////////////////////////////////////////////////////////////////////
    // sequencer states
    ////////////////////////////////////////////////////////////////////

    // sClear wipes the register file, the two load states write the seeds,
    // sStep produces one summed term per cycle
    typedef enum logic [2:0] {
        sIdle,
        sClear,
        sLoadA,
        sLoadB,
        sStep,
        sDone
    } seqState;

    ////////////////////////////////////////////////////////////////////
    // alu opcodes and write-back source
    ////////////////////////////////////////////////////////////////////

    // opNop on every cycle that writes nothing
    typedef enum logic [1:0] {
        opNop,
        opAdd,
        opPassA
    } aluOp;

    // seed straight from the sequencer, or the alu result
    typedef enum logic {
        wbSeed,
        wbAlu
    } wbSel;

endpackage

//--- design/fibSequencer.sv
`timescale 1ns/1ps
`include "fibCalc_defines.svh"

module fibSequencer (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      start,
    input  logic [`FIB_DATA_W-1:0]    seedA,
    input  logic [`FIB_DATA_W-1:0]    seedB,
    input  logic [`FIB_COUNT_W-1:0]   termCount,
    input  logic [`FIB_REG_IDX_W-1:0] readSel,
    input  logic                      carryFlag,
    output logic [`FIB_REG_IDX_W-1:0] regRead1,
    output logic [`FIB_REG_IDX_W-1:0] regRead2,
    output logic [`FIB_REG_IDX_W-1:0] regWrite,
    output logic                      regWriteEn,
    output logic                      regClear,
    output fibCalcPkg::aluOp          aluOp,
    output fibCalcPkg::wbSel          wbSel,
    output logic [`FIB_DATA_W-1:0]    seedValue,
    output logic [`FIB_COUNT_W-1:0]   termNumber,
    output logic                      lastStep,
    output logic                      busy
);

    fibCalcPkg::seqState       state;
    fibCalcPkg::seqState       nextState;
    logic [`FIB_COUNT_W-1:0]   stepCount;
    logic [`FIB_COUNT_W-1:0]   lastCount;
    logic [`FIB_REG_IDX_W-1:0] writeIdx;
    logic                      stepWrite;
    logic                      atLast;

    ////////////////////////////////////////////////////////////////////
    // state decode
    ////////////////////////////////////////////////////////////////////

    assign busy = (state != fibCalcPkg::sIdle);

    // carry latched by the previous add ends the run, nothing more is written
    assign stepWrite = (state == fibCalcPkg::sStep) && !carryFlag;

    // term being written is the final one asked for
    assign atLast = (stepCount == lastCount);

    always_comb begin
        nextState = state;
        case (state)
            fibCalcPkg::sIdle: begin
                if (start) begin
                    nextState = fibCalcPkg::sClear;
                end
            end
            fibCalcPkg::sClear:  nextState = fibCalcPkg::sLoadA;
            // lastCount is at least 1, so term 0 never ends a run
            fibCalcPkg::sLoadA:  nextState = fibCalcPkg::sLoadB;
            fibCalcPkg::sLoadB: begin
                if (atLast) begin
                    nextState = fibCalcPkg::sDone;
                end else begin
                    nextState = fibCalcPkg::sStep;
                end
            end
            fibCalcPkg::sStep: begin
                if (!stepWrite || atLast) begin
                    nextState = fibCalcPkg::sDone;
                end
            end
            fibCalcPkg::sDone:   nextState = fibCalcPkg::sIdle;
            default:             nextState = fibCalcPkg::sIdle;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // state, term counter and rotating write pointer
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= fibCalcPkg::sIdle;
            stepCount <= '0;
            writeIdx  <= '0;
            lastCount <= `FIB_COUNT_W'(1);
        end else begin
            state <= nextState;
            if (state == fibCalcPkg::sIdle && start) begin
                stepCount <= '0;
                writeIdx  <= '0;
                // a count of 0 still runs through both seeds
                lastCount <= (termCount == '0) ? `FIB_COUNT_W'(1) : termCount;
            end else if (regWriteEn) begin
                stepCount <= stepCount + 1'b1;
                // wraps mod 16 on its own
                writeIdx  <= writeIdx + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // datapath controls
    ////////////////////////////////////////////////////////////////////

    assign regClear   = (state == fibCalcPkg::sClear);
    assign regWriteEn = (state == fibCalcPkg::sLoadA) || (state == fibCalcPkg::sLoadB) ||
                        stepWrite;
    assign regWrite   = writeIdx;

    // operands are the two terms just behind the write pointer
    assign regRead1 = writeIdx - `FIB_REG_IDX_W'(1);
    // port 2 doubles as the external read port while idle
    assign regRead2 = busy ? (writeIdx - `FIB_REG_IDX_W'(2)) : readSel;

    always_comb begin
        case (state)
            fibCalcPkg::sLoadA, fibCalcPkg::sLoadB: aluOp = fibCalcPkg::opPassA;
            fibCalcPkg::sStep: begin
                aluOp = stepWrite ? fibCalcPkg::opAdd : fibCalcPkg::opNop;
            end
            default: aluOp = fibCalcPkg::opNop;
        endcase
    end

    assign wbSel     = (state == fibCalcPkg::sStep) ? fibCalcPkg::wbAlu : fibCalcPkg::wbSeed;
    assign seedValue = (state == fibCalcPkg::sLoadB) ? seedB : seedA;

    // tag for the result stage report
    assign termNumber = stepCount;
    assign lastStep   = regWriteEn && atLast;

endmodule

//--- design/registerFile.sv
`timescale 1ns/1ps
`include "fibCalc_defines.svh"

module registerFile (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      regClear,
    input  logic [`FIB_REG_IDX_W-1:0] regRead1,
    input  logic [`FIB_REG_IDX_W-1:0] regRead2,
    input  logic [`FIB_REG_IDX_W-1:0] regWrite,
    input  logic                      regWriteEn,
    input  logic [`FIB_DATA_W-1:0]    writeData,
    output logic [`FIB_DATA_W-1:0]    aBus,
    output logic [`FIB_DATA_W-1:0]    bBus
);

    logic [`FIB_DATA_W-1:0] regs [`FIB_NUM_REGS];

    ////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////

    // all registers read zero after reset and after a clear
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `FIB_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (regClear) begin
            // clear wins over a write in the same cycle
            for (int i = 0; i < `FIB_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (regWriteEn) begin
            regs[regWrite] <= writeData;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // read ports
    ////////////////////////////////////////////////////////////////////

    // combinational, old value is seen during the write cycle
    assign aBus = regs[regRead1];
    // also the external read port
    assign bBus = regs[regRead2];

endmodule

//--- design/alu.sv
`timescale 1ns/1ps
`include "fibCalc_defines.svh"

module alu (
    input  logic [`FIB_DATA_W-1:0] aBus,
    input  logic [`FIB_DATA_W-1:0] bBus,
    input  fibCalcPkg::aluOp       aluOp,
    output logic [`FIB_DATA_W-1:0] result,
    output logic                   carry,
    output logic                   overflowRaw,
    output logic                   negative,
    output logic                   zero
);

    logic [`FIB_DATA_W:0]   sumWide;
    logic                   signA;
    logic                   signB;
    logic                   signSum;

    ////////////////////////////////////////////////////////////////////
    // adder
    ////////////////////////////////////////////////////////////////////

    // one extra bit catches the unsigned carry out
    assign sumWide = {1'b0, aBus} + {1'b0, bBus};

    assign signA   = aBus[`FIB_DATA_W-1];
    assign signB   = bBus[`FIB_DATA_W-1];
    assign signSum = sumWide[`FIB_DATA_W-1];

    ////////////////////////////////////////////////////////////////////
    // op select
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        case (aluOp)
            fibCalcPkg::opAdd: begin
                result      = sumWide[`FIB_DATA_W-1:0];
                carry       = sumWide[`FIB_DATA_W];
                // like signs in, other sign out
                overflowRaw = (signA == signB) && (signSum != signA);
            end
            fibCalcPkg::opPassA: begin
                result      = aBus;
                carry       = 1'b0;
                overflowRaw = 1'b0;
            end
            default: begin
                // idle cycles drive a quiet zero
                result      = '0;
                carry       = 1'b0;
                overflowRaw = 1'b0;
            end
        endcase
    end

    // flags of whatever is on the result
    assign negative = result[`FIB_DATA_W-1];
    assign zero     = (result == '0);

endmodule

//--- design/resultStage.sv
`timescale 1ns/1ps
`include "fibCalc_defines.svh"

module resultStage (
    input  logic                    clk,
    input  logic                    rstN,
    input  fibCalcPkg::wbSel        wbSel,
    input  logic [`FIB_DATA_W-1:0]  seedValue,
    input  logic [`FIB_DATA_W-1:0]  result,
    input  logic                    carry,
    input  logic                    overflowRaw,
    input  logic                    negative,
    input  logic                    zero,
    input  logic                    regWriteEn,
    input  logic [`FIB_COUNT_W-1:0] termNumber,
    input  logic                    lastStep,
    output logic [`FIB_DATA_W-1:0]  writeData,
    output logic                    carryFlag,
    output logic                    termValid,
    output logic [`FIB_COUNT_W-1:0] termIndex,
    output logic [`FIB_DATA_W-1:0]  termValue,
    output logic                    done,
    output logic                    overflow
);

    // flag register bit positions
    localparam int FlagZ = 0;
    localparam int FlagN = 1;
    localparam int FlagV = 2;
    localparam int FlagC = 3;

    logic       fromAlu;
    logic [3:0] nextFlags;
    logic [3:0] flagReg;
    logic       stopMark;

    ////////////////////////////////////////////////////////////////////
    // write-back mux
    ////////////////////////////////////////////////////////////////////

    assign fromAlu   = (wbSel == fibCalcPkg::wbAlu);
    assign writeData = fromAlu ? result : seedValue;

    // seed writes take sign and zero from the seed itself, never a carry
    always_comb begin
        nextFlags        = '0;
        nextFlags[FlagC] = fromAlu && carry;
        nextFlags[FlagV] = fromAlu && overflowRaw;
        nextFlags[FlagN] = fromAlu ? negative : seedValue[`FIB_DATA_W-1];
        nextFlags[FlagZ] = fromAlu ? zero : (seedValue == '0);
    end

    ////////////////////////////////////////////////////////////////////
    // flags and report strobes
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            flagReg   <= '0;
            termValid <= 1'b0;
            stopMark  <= 1'b0;
            done      <= 1'b0;
        end else begin
            if (regWriteEn) begin
                flagReg <= nextFlags;
            end
            termValid <= regWriteEn;
            // report cycle of the final term or of the carrying one
            stopMark  <= regWriteEn && (lastStep || nextFlags[FlagC]);
            done      <= stopMark;
        end
    end

    // report payload, only meaningful with termValid
    always_ff @(posedge clk) begin
        if (regWriteEn) begin
            termIndex <= termNumber;
            termValue <= writeData;
        end
    end

    // the carry stops the run, so the flag holds until the seed write of the next one
    assign carryFlag = flagReg[FlagC];
    assign overflow  = flagReg[FlagC];

endmodule

//--- design/fibCalc.sv
`timescale 1ns/1ps
`include "fibCalc_defines.svh"

module fibCalc (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      start,
    input  logic [`FIB_DATA_W-1:0]    seedA,
    input  logic [`FIB_DATA_W-1:0]    seedB,
    input  logic [`FIB_COUNT_W-1:0]   termCount,
    input  logic [`FIB_REG_IDX_W-1:0] readSel,
    output logic                      termValid,
    output logic [`FIB_COUNT_W-1:0]   termIndex,
    output logic [`FIB_DATA_W-1:0]    termValue,
    output logic                      done,
    output logic                      overflow,
    output logic                      busy,
    output logic [`FIB_DATA_W-1:0]    readData
);

    ////////////////////////////////////////////////////////////////////
    // interconnect
    ////////////////////////////////////////////////////////////////////

    // sequencer to datapath
    logic [`FIB_REG_IDX_W-1:0] regRead1;
    logic [`FIB_REG_IDX_W-1:0] regRead2;
    logic [`FIB_REG_IDX_W-1:0] regWrite;
    logic                      regWriteEn;
    logic                      regClear;
    fibCalcPkg::aluOp          aluOp;
    fibCalcPkg::wbSel          wbSel;
    logic [`FIB_DATA_W-1:0]    seedValue;
    logic [`FIB_COUNT_W-1:0]   termNumber;
    logic                      lastStep;

    // register file to alu
    logic [`FIB_DATA_W-1:0]    aBus;
    logic [`FIB_DATA_W-1:0]    bBus;

    // alu to result stage
    logic [`FIB_DATA_W-1:0]    result;
    logic                      carry;
    logic                      overflowRaw;
    logic                      negative;
    logic                      zero;

    // result stage back around
    logic [`FIB_DATA_W-1:0]    writeData;
    logic                      carryFlag;

    // idle read port rides on the B bus
    assign readData = bBus;

    fibSequencer i_fibSequencer (
        .clk(clk), .rstN(rstN), .start(start), .seedA(seedA), .seedB(seedB),
        .termCount(termCount), .readSel(readSel), .carryFlag(carryFlag),
        .regRead1(regRead1), .regRead2(regRead2), .regWrite(regWrite),
        .regWriteEn(regWriteEn), .regClear(regClear), .aluOp(aluOp), .wbSel(wbSel),
        .seedValue(seedValue), .termNumber(termNumber), .lastStep(lastStep), .busy(busy)
    );

    registerFile i_registerFile (
        .clk(clk), .rstN(rstN), .regClear(regClear), .regRead1(regRead1),
        .regRead2(regRead2), .regWrite(regWrite), .regWriteEn(regWriteEn),
        .writeData(writeData), .aBus(aBus), .bBus(bBus)
    );

    alu i_alu (
        .aBus(aBus), .bBus(bBus), .aluOp(aluOp), .result(result), .carry(carry),
        .overflowRaw(overflowRaw), .negative(negative), .zero(zero)
    );

    resultStage i_resultStage (
        .clk(clk), .rstN(rstN), .wbSel(wbSel), .seedValue(seedValue), .result(result),
        .carry(carry), .overflowRaw(overflowRaw), .negative(negative), .zero(zero),
        .regWriteEn(regWriteEn), .termNumber(termNumber), .lastStep(lastStep),
        .writeData(writeData), .carryFlag(carryFlag), .termValid(termValid),
        .termIndex(termIndex), .termValue(termValue), .done(done), .overflow(overflow)
    );

endmodule

//--- test/fibCalcTb.sv
`timescale 1ns/1ps
`include "fibCalc_defines.svh"

module fibCalcTb;

    localparam int NumRandom = 20;
    localparam int NumTests  = NumRandom + 3;
    // every run budgeted at the longest count, plus a full readback
    localparam int TestCycles     = 31 + 8 + 34;
    localparam int WatchdogCycles = 8 + 34 + NumTests * TestCycles + 100;

    logic                      clk;
    logic                      rstN;
    logic                      start;
    logic [`FIB_DATA_W-1:0]    seedA;
    logic [`FIB_DATA_W-1:0]    seedB;
    logic [`FIB_COUNT_W-1:0]   termCount;
    logic [`FIB_REG_IDX_W-1:0] readSel;
    logic                      termValid;
    logic [`FIB_COUNT_W-1:0]   termIndex;
    logic [`FIB_DATA_W-1:0]    termValue;
    logic                      done;
    logic                      overflow;
    logic                      busy;
    logic [`FIB_DATA_W-1:0]    readData;

    // expectations of the current run, shared with the checker
    string                     curTest;
    logic [`FIB_DATA_W-1:0]    curSeedA;
    logic [`FIB_DATA_W-1:0]    curSeedB;
    int                        curLast;
    int                        carryIdx;
    logic                      expCarry;
    int                        expIdx;
    int                        doneCount;
    int                        runCount;
    int                        errorCount;
    logic [31:0]               rngState;
    logic [`FIB_DATA_W-1:0]    checkValue;

    fibCalc i_fibCalc (
        .clk(clk), .rstN(rstN), .start(start), .seedA(seedA), .seedB(seedB),
        .termCount(termCount), .readSel(readSel), .termValid(termValid),
        .termIndex(termIndex), .termValue(termValue), .done(done),
        .overflow(overflow), .busy(busy), .readData(readData)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // term k, each sum truncated to the data width
    function automatic logic [`FIB_DATA_W-1:0] refTerm(input logic [`FIB_DATA_W-1:0] a,
                                                      input logic [`FIB_DATA_W-1:0] b,
                                                      input int k);
        logic [`FIB_DATA_W-1:0] p;
        logic [`FIB_DATA_W-1:0] q;
        logic [`FIB_DATA_W:0]   s;
        p = a;
        q = b;
        for (int i = 2; i <= k; i++) begin
            s = {1'b0, p} + {1'b0, q};
            p = q;
            q = s[`FIB_DATA_W-1:0];
        end
        return (k == 0) ? a : q;
    endfunction

    // first term whose sum carries out, 32 if none within range
    function automatic int firstCarry(input logic [`FIB_DATA_W-1:0] a,
                                      input logic [`FIB_DATA_W-1:0] b);
        logic [`FIB_DATA_W-1:0] p;
        logic [`FIB_DATA_W-1:0] q;
        logic [`FIB_DATA_W:0]   s;
        int                     found;
        p     = a;
        q     = b;
        found = 32;
        for (int k = 2; k < 32; k++) begin
            s = {1'b0, p} + {1'b0, q};
            if (s[`FIB_DATA_W] && found == 32) begin
                found = k;
            end
            p = q;
            q = s[`FIB_DATA_W-1:0];
        end
        return found;
    endfunction

    // last term that landed in register r, zero if never written
    function automatic logic [`FIB_DATA_W-1:0] regExpect(input int r);
        logic [`FIB_DATA_W-1:0] value;
        value = '0;
        if (r <= curLast) begin
            value = refTerm(curSeedA, curSeedB, r + 16 * ((curLast - r) / 16));
        end
        return value;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checker
    //////////////////////////////////////////////////////////////////////

    // outputs are registered, so mid-cycle is stable
    always @(negedge clk) begin
        if (rstN && termValid) begin
            if (expIdx > curLast) begin
                $display("unexpected term %0d reported after the last one in %s",
                         termIndex, curTest);
                errorCount++;
            end else begin
                checkValue = refTerm(curSeedA, curSeedB, expIdx);
                if (int'(termIndex) != expIdx) begin
                    $display("MISMATCH %s termIndex expected %0d actual %0d",
                             curTest, expIdx, termIndex);
                    errorCount++;
                end
                if (termValue != checkValue) begin
                    $display("MISMATCH %s term %0d expected %0d actual %0d",
                             curTest, expIdx, checkValue, termValue);
                    errorCount++;
                end
                // flag follows the carry of the term just written
                if (overflow != (expIdx == carryIdx)) begin
                    $display("MISMATCH %s overflow at term %0d expected %0d actual %0d",
                             curTest, expIdx, (expIdx == carryIdx), overflow);
                    errorCount++;
                end
            end
            expIdx++;
        end
        if (rstN && done) begin
            doneCount++;
            if (expIdx != curLast + 1) begin
                $display("done pulsed after %0d of %0d terms in %s",
                         expIdx, curLast + 1, curTest);
                errorCount++;
            end
            if (overflow != expCarry) begin
                $display("MISMATCH %s overflow at done expected %0d actual %0d",
                         curTest, expCarry, overflow);
                errorCount++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus tasks
    //////////////////////////////////////////////////////////////////////

    task automatic checkReadback();
        for (int r = 0; r < `FIB_NUM_REGS; r++) begin
            @(negedge clk);
            readSel = `FIB_REG_IDX_W'(r);
            @(negedge clk);
            if (readData != regExpect(r)) begin
                $display("MISMATCH %s readData r%0d expected %0d actual %0d",
                         curTest, r, regExpect(r), readData);
                errorCount++;
            end
        end
    endtask

    task automatic runTest(input string name, input logic [`FIB_DATA_W-1:0] a,
                           input logic [`FIB_DATA_W-1:0] b,
                           input logic [`FIB_COUNT_W-1:0] count, input bit pulseBusy);
        int clamped;
        int waited;
        clamped = (count == '0) ? 1 : int'(count);
        @(negedge clk);
        curTest  = name;
        curSeedA = a;
        curSeedB = b;
        carryIdx = firstCarry(a, b);
        expCarry = (carryIdx <= clamped);
        curLast  = expCarry ? carryIdx : clamped;
        expIdx   = 0;
        runCount++;
        seedA     = a;
        seedB     = b;
        termCount = count;
        start     = 1'b1;
        @(negedge clk);
        start = 1'b0;
        // start taken at the edge just passed
        if (!busy) begin
            $display("engine not busy after start in %s", name);
            errorCount++;
        end
        if (pulseBusy) begin
            // second start mid-run with a shorter count, must be ignored
            repeat (5) @(negedge clk);
            start     = 1'b1;
            termCount = `FIB_COUNT_W'(5);
            @(negedge clk);
            start = 1'b0;
        end
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!done && waited < clamped + 16);
        if (!done) begin
            $display("no done pulse within %0d cycles in %s", waited, name);
            errorCount++;
        end
        // a carry stop leaves busy up for one more cycle
        waited = 0;
        while (busy && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        if (busy) begin
            $display("engine still busy after done in %s", name);
            errorCount++;
        end
        @(negedge clk);
        if (expIdx != curLast + 1 || doneCount != runCount) begin
            $display("%s reported %0d terms and %0d done pulses over %0d runs",
                     name, expIdx, doneCount, runCount);
            errorCount++;
        end
        checkReadback();
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [`FIB_DATA_W-1:0]  ra;
        logic [`FIB_DATA_W-1:0]  rb;
        logic [`FIB_COUNT_W-1:0] rc;
        clk        = 1'b0;
        rstN       = 1'b0;
        start      = 1'b0;
        seedA      = '0;
        seedB      = '0;
        termCount  = '0;
        readSel    = '0;
        curTest    = "reset";
        curSeedA   = '0;
        curSeedB   = '0;
        curLast    = -1;
        carryIdx   = 32;
        expCarry   = 1'b0;
        expIdx     = 0;
        doneCount  = 0;
        runCount   = 0;
        errorCount = 0;
        rngState   = 32'h22d8810b;
        repeat (8) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        if (termValid || done || overflow || busy) begin
            $display("outputs not idle after reset: termValid %0d done %0d overflow %0d busy %0d",
                     termValid, done, overflow, busy);
            errorCount++;
        end
        // curLast of -1 expects every register at zero
        checkReadback();
        runTest("fib16", 16'd0, 16'd1, 5'd15, 1'b0);
        runTest("fibWrap", 16'd0, 16'd1, 5'd31, 1'b0);
        for (int i = 0; i < NumRandom; i++) begin
            // random shift spreads seed sizes, so runs end by count and by carry
            rngState = lcgNext(rngState);
            ra       = rngState[31:16] >> rngState[11:8];
            rngState = lcgNext(rngState);
            rb       = rngState[31:16] >> rngState[11:8];
            rngState = lcgNext(rngState);
            rc       = rngState[31:27];
            runTest($sformatf("random%0d", i), ra, rb, rc, 1'b0);
        end
        runTest("startWhileBusy", 16'd3, 16'd5, 5'd20, 1'b1);
        $display("%0d runs checked, %0d errors", runCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("watchdog expired after %0d cycles in %s, %0d errors so far",
                 WatchdogCycles, curTest, errorCount);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- fibCalc.f
+incdir+design
design/fibCalcPkg.sv
design/fibSequencer.sv
design/registerFile.sv
design/alu.sv
design/resultStage.sv
design/fibCalc.sv
test/fibCalcTb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := fibCalcTb
RTL_TOP    := fibCalc
FILELIST   := fibCalc.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := CHECKS FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
